// ==== logic/avr_isa_pkg.sv ====
// ================================================
// Instruction set definitions of the AVR core.
// Opcode and instruction class enums, addressing
// forms, status bit positions and pointer registers.
// ================================================

package avr_isa_pkg;

	// Operations carried out by the ALU in one cycle.
	typedef enum logic [4:0] {
		op_add, op_adc, op_sub, op_sbc,
		op_and, op_or, op_eor, op_mov, op_ldi,
		op_com, op_neg, op_inc, op_dec,
		op_lsr, op_ror, op_asr, op_swap, op_nop
	} alu_op_e;

	// Instruction kinds that the sequencer treats differently.
	typedef enum logic [2:0] {
		cls_alu, cls_rjmp, cls_branch, cls_load, cls_store, cls_out
	} instr_class_e;

	typedef enum logic [1:0] {
		mode_plain, mode_post_inc, mode_pre_dec
	} ptr_mode_e;

	typedef enum logic [1:0] {
		ptr_x, ptr_y, ptr_z
	} ptr_sel_e;

	// Status register bit numbers as used by BRBS and BRBC.
	localparam logic [2:0] sreg_c = 3'd0;
	localparam logic [2:0] sreg_z = 3'd1;
	localparam logic [2:0] sreg_n = 3'd2;
	localparam logic [2:0] sreg_v = 3'd3;
	localparam logic [2:0] sreg_s = 3'd4;
	localparam logic [2:0] sreg_h = 3'd5;

	// Low byte of each pointer pair; the high byte is the next register.
	localparam logic [4:0] reg_xl = 5'd26;
	localparam logic [4:0] reg_yl = 5'd28;
	localparam logic [4:0] reg_zl = 5'd30;

endpackage

// ==== logic/avr_core_pkg.sv ====
// ================================================
// Microarchitecture definitions of the AVR core.
// Memory widths, sequencer states and the structs
// passed between the core blocks.
// ================================================

package avr_core_pkg;

	// Program address in 16-bit words, data address in bytes.
	localparam int pmem_width = 11;
	localparam int dmem_width = 13;

	typedef enum logic [1:0] {
		st_normal, st_stall, st_writeback
	} seq_state_e;

	// h is declared first so that c sits at bit 0, matching the AVR layout.
	typedef struct packed {
		logic h;
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} sreg_t;

	typedef struct packed {
		avr_isa_pkg::instr_class_e iclass;
		avr_isa_pkg::alu_op_e      alu_op;
		logic [4:0]                rd;
		logic [4:0]                rr;
		logic [7:0]                imm;
		logic                      use_imm;
		logic                      change_z;
		logic                      writeback;
		avr_isa_pkg::ptr_sel_e     ptr_sel;
		avr_isa_pkg::ptr_mode_e    ptr_mode;
		logic [2:0]                branch_bit;
		logic                      branch_if_set;
		logic [11:0]               offset;
		logic [5:0]                io_addr;
	} decoded_t;

	typedef struct packed {
		logic                  we;
		logic [dmem_width-1:0] addr;
		logic [7:0]            wdata;
	} dmem_req_t;

	typedef struct packed {
		logic       we;
		logic [5:0] addr;
		logic [7:0] data;
	} io_wr_t;

endpackage

// ==== logic/instr_decoder.sv ====
// ================================================
// Instruction decoder.
// Splits a fetched AVR word into register numbers,
// immediate, ALU operation and control fields.
// ================================================

`timescale 1ns/100ps

module instr_decoder (
	input  logic [15:0]             pmem_d,
	output avr_core_pkg::decoded_t  dec
);
	import avr_isa_pkg::*;

	logic ls_valid;

	always_comb begin
		ls_valid = 1'b1;
		dec.iclass = cls_alu;
		dec.alu_op = op_nop;
		dec.rd = pmem_d[8:4];
		dec.rr = {pmem_d[9], pmem_d[3:0]};
		dec.imm = {pmem_d[11:8], pmem_d[3:0]};
		dec.use_imm = 1'b0;
		dec.change_z = 1'b1;
		dec.writeback = 1'b0;
		dec.ptr_sel = ptr_z;
		dec.ptr_mode = mode_plain;
		dec.branch_bit = pmem_d[2:0];
		dec.branch_if_set = ~pmem_d[10];
		dec.offset = pmem_d[11:0];
		dec.io_addr = {pmem_d[10:9], pmem_d[3:0]};
		casez (pmem_d)
			16'b000?_11??_????_????: begin
				dec.alu_op = pmem_d[12] ? op_adc : op_add;
				dec.writeback = 1'b1;
			end
			// Bit 12 clear selects the carry forms SBC and CPC.
			16'b000?_10??_????_????, 16'b000?_01??_????_????: begin
				dec.alu_op = pmem_d[12] ? op_sub : op_sbc;
				dec.change_z = pmem_d[12];
				dec.writeback = pmem_d[11];
			end
			16'b0011_????_????_????, 16'b010?_????_????_????: begin
				dec.alu_op = pmem_d[12] ? op_sub : op_sbc;
				dec.change_z = pmem_d[12];
				dec.writeback = pmem_d[14];
			end
			16'b0010_00??_????_????: dec.alu_op = op_and;
			16'b0010_01??_????_????: dec.alu_op = op_eor;
			16'b0010_10??_????_????: dec.alu_op = op_or;
			16'b0010_11??_????_????: dec.alu_op = op_mov;
			16'b0110_????_????_????: dec.alu_op = op_or;
			16'b0111_????_????_????: dec.alu_op = op_and;
			16'b1110_????_????_????: dec.alu_op = op_ldi;
			16'b1001_010?_????_????: begin
				case (pmem_d[3:0])
					4'h0: dec.alu_op = op_com;
					4'h1: dec.alu_op = op_neg;
					4'h2: dec.alu_op = op_swap;
					4'h3: dec.alu_op = op_inc;
					4'h5: dec.alu_op = op_asr;
					4'h6: dec.alu_op = op_lsr;
					4'h7: dec.alu_op = op_ror;
					4'ha: dec.alu_op = op_dec;
					default: dec.alu_op = op_nop;
				endcase
			end
			16'b1001_00??_????_????: begin
				case (pmem_d[3:0])
					4'hc: dec.ptr_sel = ptr_x;
					4'hd: {dec.ptr_sel, dec.ptr_mode} = {ptr_x, mode_post_inc};
					4'he: {dec.ptr_sel, dec.ptr_mode} = {ptr_x, mode_pre_dec};
					4'h9: {dec.ptr_sel, dec.ptr_mode} = {ptr_y, mode_post_inc};
					4'ha: {dec.ptr_sel, dec.ptr_mode} = {ptr_y, mode_pre_dec};
					4'h1: dec.ptr_mode = mode_post_inc;
					4'h2: dec.ptr_mode = mode_pre_dec;
					default: ls_valid = 1'b0;
				endcase
				if (ls_valid)
					dec.iclass = pmem_d[9] ? cls_store : cls_load;
			end
			// Plain Y and Z accesses share the displacement encoding with q = 0.
			16'b1000_00??_????_?000: begin
				dec.ptr_sel = pmem_d[3] ? ptr_y : ptr_z;
				dec.iclass = pmem_d[9] ? cls_store : cls_load;
			end
			16'b1011_1???_????_????: dec.iclass = cls_out;
			16'b1100_????_????_????: dec.iclass = cls_rjmp;
			16'b1111_0???_????_????: begin
				dec.iclass = cls_branch;
				dec.offset = {{5{pmem_d[9]}}, pmem_d[9:3]};
			end
			default: dec.alu_op = op_nop;
		endcase
		// Immediate forms only reach R16 to R31.
		if (pmem_d[15:14] == 2'b01 || pmem_d[15:12] == 4'b0011 || pmem_d[15:13] == 3'b111) begin
			dec.use_imm = 1'b1;
			dec.rd = {1'b1, pmem_d[7:4]};
		end
		if (dec.iclass == cls_alu && dec.alu_op inside {op_and, op_or, op_eor, op_mov, op_ldi,
				op_com, op_neg, op_inc, op_dec, op_lsr, op_ror, op_asr, op_swap})
			dec.writeback = 1'b1;
	end

endmodule

// ==== logic/alu.sv ====
// ================================================
// ALU of the AVR core.
// Result and next status flags for one operation.
// ================================================

`timescale 1ns/100ps

module alu (
	input  avr_isa_pkg::alu_op_e op,
	input  logic [7:0]           a,
	input  logic [7:0]           b,
	input  logic                 carry_in,
	input  avr_core_pkg::sreg_t  flags_in,
	input  logic                 change_z,
	output logic [7:0]           result,
	output avr_core_pkg::sreg_t  flags_out
);
	import avr_isa_pkg::*;

	logic [8:0] sum;
	logic [7:0] r;
	logic       v;
	logic       update_svnz;

	always_comb begin
		sum = 9'd0;
		r = a;
		v = flags_in.v;
		update_svnz = 1'b1;
		flags_out = flags_in;
		case (op)
			op_add, op_adc: begin
				sum = {1'b0, a} + {1'b0, b} + {8'd0, carry_in & (op == op_adc)};
				r = sum[7:0];
				flags_out.c = sum[8];
				flags_out.h = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
				v = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
			end
			op_sub, op_sbc: begin
				sum = {1'b0, a} - {1'b0, b} - {8'd0, carry_in & (op == op_sbc)};
				r = sum[7:0];
				flags_out.c = sum[8];
				flags_out.h = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
				v = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
			end
			op_and: {r, v} = {a & b, 1'b0};
			op_or:  {r, v} = {a | b, 1'b0};
			op_eor: {r, v} = {a ^ b, 1'b0};
			op_com: begin
				r = ~a;
				v = 1'b0;
				flags_out.c = 1'b1;
			end
			op_neg: begin
				sum = 9'd0 - {1'b0, a};
				r = sum[7:0];
				flags_out.c = sum[8];
				flags_out.h = r[3] | a[3];
				v = (r == 8'h80);
			end
			op_inc: begin
				r = a + 8'd1;
				v = (r == 8'h80);
			end
			op_dec: begin
				r = a - 8'd1;
				v = (r == 8'h7f);
			end
			op_lsr, op_ror, op_asr: begin
				// ROR shifts the old carry in, ASR keeps the sign bit.
				r = {(carry_in & (op == op_ror)) | (a[7] & (op == op_asr)), a[7:1]};
				flags_out.c = a[0];
				v = r[7] ^ a[0];
			end
			op_mov, op_ldi: {r, update_svnz} = {b, 1'b0};
			op_swap: {r, update_svnz} = {a[3:0], a[7:4], 1'b0};
			default: update_svnz = 1'b0;
		endcase
		if (update_svnz) begin
			flags_out.n = r[7];
			flags_out.v = v;
			flags_out.s = r[7] ^ v;
			// The carry forms may clear Z but never set it.
			flags_out.z = (r == 8'h00) & (change_z | flags_in.z);
		end
		result = r;
	end

endmodule

// ==== logic/register_file.sv ====
// ================================================
// General register file and status register.
// 32 registers with X, Y and Z pointer views.
// ================================================

`timescale 1ns/100ps

module register_file (
	input  logic                   clk,
	input  logic                   rst,
	input  avr_core_pkg::decoded_t dec,
	input  logic                   alu_we,
	input  logic                   load_we,
	input  logic [7:0]             alu_result,
	input  avr_core_pkg::sreg_t    alu_flags,
	input  logic [7:0]             load_data,
	input  logic                   ptr_update,
	output logic [7:0]             rd_val,
	output logic [7:0]             rr_val,
	output logic [15:0]            ptr_val,
	output avr_core_pkg::sreg_t    sreg
);
	import avr_isa_pkg::*;

	logic [7:0]  regs [32];
	logic [4:0]  ptr_lo;
	logic [4:0]  ptr_hi;
	logic [15:0] ptr_next;

	always_comb begin
		case (dec.ptr_sel)
			ptr_x: ptr_lo = reg_xl;
			ptr_y: ptr_lo = reg_yl;
			default: ptr_lo = reg_zl;
		endcase
	end

	assign ptr_hi = ptr_lo + 5'd1;
	assign ptr_val = {regs[ptr_hi], regs[ptr_lo]};
	assign ptr_next = (dec.ptr_mode == mode_post_inc) ? ptr_val + 16'd1 : ptr_val - 16'd1;

	// The second operand is the immediate for the K forms.
	assign rd_val = regs[dec.rd];
	assign rr_val = dec.use_imm ? dec.imm : regs[dec.rr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 8'd0;
			sreg <= '0;
		end else begin
			if (alu_we) begin
				sreg <= alu_flags;
				if (dec.writeback)
					regs[dec.rd] <= alu_result;
			end
			if (load_we)
				regs[dec.rd] <= load_data;
			if (ptr_update) begin
				regs[ptr_lo] <= ptr_next[7:0];
				regs[ptr_hi] <= ptr_next[15:8];
			end
		end
	end

	// The sequencer steps pointers only in the address cycle of LD and ST.
	assert property (@(posedge clk) disable iff (rst)
		!(((alu_we && dec.writeback) || load_we) && ptr_update));

endmodule

// ==== logic/sequencer.sv ====
// ================================================
// Sequencer of the AVR core.
// State machine, program counter, fetch control,
// branch test and data and I/O requests.
// ================================================

`timescale 1ns/100ps

module sequencer (
	input  logic                                clk,
	input  logic                                rst,
	input  avr_core_pkg::decoded_t              dec,
	input  avr_core_pkg::sreg_t                 sreg,
	input  logic [7:0]                          rd_val,
	input  logic [15:0]                         ptr_val,
	output logic                                pmem_ce,
	output logic [avr_core_pkg::pmem_width-1:0] pmem_a,
	output avr_core_pkg::dmem_req_t             dmem_req,
	output avr_core_pkg::io_wr_t                io_wr,
	output logic                                alu_we,
	output logic                                load_we,
	output logic                                ptr_update,
	output logic [avr_core_pkg::pmem_width-1:0] dbg_pc
);
	import avr_isa_pkg::*;
	import avr_core_pkg::*;

	seq_state_e            state;
	seq_state_e            next_state;
	logic [pmem_width-1:0] pc;
	logic [pmem_width-1:0] pc_next;
	logic [pmem_width-1:0] pc_inc;
	logic                  flag_bit;
	logic                  taken;

	always_comb begin
		case (dec.branch_bit)
			sreg_c: flag_bit = sreg.c;
			sreg_z: flag_bit = sreg.z;
			sreg_n: flag_bit = sreg.n;
			sreg_v: flag_bit = sreg.v;
			sreg_s: flag_bit = sreg.s;
			sreg_h: flag_bit = sreg.h;
			default: flag_bit = 1'b0;
		endcase
	end
	assign taken = (flag_bit == dec.branch_if_set);

	// pc is the address of the word currently on pmem_d.
	assign pc_inc = pc + 1'b1;
	assign pmem_a = rst ? '0 : pc_inc;
	assign dbg_pc = pc;

	always_comb begin
		next_state = state;
		pc_next = pc;
		pmem_ce = rst;
		alu_we = 1'b0;
		load_we = 1'b0;
		ptr_update = 1'b0;
		dmem_req.we = 1'b0;
		dmem_req.addr = dmem_width'(dec.ptr_mode == mode_pre_dec ? ptr_val - 16'd1 : ptr_val);
		dmem_req.wdata = rd_val;
		io_wr.we = 1'b0;
		io_wr.addr = dec.io_addr;
		io_wr.data = rd_val;
		case (state)
			// nothing is issued while reset is held.
			st_normal: if (!rst) begin
				case (dec.iclass)
					cls_rjmp: begin
						pc_next = pc + pmem_width'(dec.offset);
						next_state = st_stall;
					end
					cls_branch: begin
						if (taken) begin
							pc_next = pc + pmem_width'(dec.offset);
							next_state = st_stall;
						end else begin
							pc_next = pc_inc;
							pmem_ce = 1'b1;
						end
					end
					// The LD word stays on pmem_d until the writeback cycle.
					cls_load: begin
						ptr_update = (dec.ptr_mode != mode_plain);
						next_state = st_writeback;
					end
					cls_store: begin
						dmem_req.we = 1'b1;
						ptr_update = (dec.ptr_mode != mode_plain);
						pc_next = pc_inc;
						pmem_ce = 1'b1;
					end
					cls_out: begin
						io_wr.we = 1'b1;
						pc_next = pc_inc;
						pmem_ce = 1'b1;
					end
					default: begin
						alu_we = 1'b1;
						pc_next = pc_inc;
						pmem_ce = 1'b1;
					end
				endcase
			end
			st_writeback: begin
				load_we = 1'b1;
				pc_next = pc_inc;
				pmem_ce = 1'b1;
				next_state = st_normal;
			end
			default: begin
				// Fetch the jump target.
				pc_next = pc_inc;
				pmem_ce = 1'b1;
				next_state = st_normal;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_normal;
			pc <= '0;
		end else begin
			state <= next_state;
			pc <= pc_next;
		end
	end

	assert property (@(posedge clk) disable iff (rst) dmem_req.we |-> state == st_normal);

	assert property (@(posedge clk) disable iff (rst)
		(state == st_normal && dec.iclass == cls_branch && taken) |=> state == st_stall);

endmodule

// ==== logic/avr_core.sv ====
// ================================================
// Top level of the AVR core.
// Connects decoder, ALU, register file and sequencer.
// ================================================

`timescale 1ns/100ps

module avr_core (
	input  logic                                clk,
	input  logic                                rst,
	output logic                                pmem_ce,
	output logic [avr_core_pkg::pmem_width-1:0] pmem_a,
	input  logic [15:0]                         pmem_d,
	output avr_core_pkg::dmem_req_t             dmem_req,
	input  logic [7:0]                          dmem_di,
	output avr_core_pkg::io_wr_t                io_wr,
	output logic [avr_core_pkg::pmem_width-1:0] dbg_pc
);
	import avr_core_pkg::*;

	decoded_t    dec;
	sreg_t       sreg;
	sreg_t       alu_flags;
	logic [7:0]  rd_val;
	logic [7:0]  rr_val;
	logic [7:0]  alu_result;
	logic [15:0] ptr_val;
	logic        alu_we;
	logic        load_we;
	logic        ptr_update;

	instr_decoder i_decoder (
		.pmem_d (pmem_d),
		.dec    (dec)
	);

	alu i_alu (
		.op        (dec.alu_op),
		.a         (rd_val),
		.b         (rr_val),
		.carry_in  (sreg.c),
		.flags_in  (sreg),
		.change_z  (dec.change_z),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

	register_file i_regs (
		.clk        (clk),
		.rst        (rst),
		.dec        (dec),
		.alu_we     (alu_we),
		.load_we    (load_we),
		.alu_result (alu_result),
		.alu_flags  (alu_flags),
		.load_data  (dmem_di),
		.ptr_update (ptr_update),
		.rd_val     (rd_val),
		.rr_val     (rr_val),
		.ptr_val    (ptr_val),
		.sreg       (sreg)
	);

	sequencer i_seq (
		.clk        (clk),
		.rst        (rst),
		.dec        (dec),
		.sreg       (sreg),
		.rd_val     (rd_val),
		.ptr_val    (ptr_val),
		.pmem_ce    (pmem_ce),
		.pmem_a     (pmem_a),
		.dmem_req   (dmem_req),
		.io_wr      (io_wr),
		.alu_we     (alu_we),
		.load_we    (load_we),
		.ptr_update (ptr_update),
		.dbg_pc     (dbg_pc)
	);

endmodule

// ==== tests/tb_clock.sv ====
// ==================================================
// Testbench clock and reset source.
// 10 ns clock, reset held for five cycles.
// ==================================================

`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset drops 1 ns after the fifth rising edge.
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== tests/avr_core_tb.sv ====
// ==================================================
// Testbench of the AVR core.
// Program and data memory models, the cases file
// reader, the write event checker and the timeout.
// ==================================================

`timescale 1ns/100ps

module avr_core_tb;
	import avr_core_pkg::*;

	localparam int drive_delay = 1;

	// One observed or expected write, data memory or I/O port.
	typedef struct packed {
		logic        is_io;
		logic [12:0] addr;
		logic [7:0]  data;
	} wr_event_t;

	logic                  clk;
	logic                  rst;
	logic                  pmem_ce;
	logic [pmem_width-1:0] pmem_a;
	logic [15:0]           pmem_d;
	dmem_req_t             dmem_req;
	logic [7:0]            dmem_di;
	io_wr_t                io_wr;
	logic [pmem_width-1:0] dbg_pc;

	logic [15:0] prog [2048];
	logic [7:0]  dmem [8192];
	wr_event_t   expected [$];

	// DUT outputs as seen in the middle of the cycle.
	logic                  ce_s = 1'b0;
	logic [pmem_width-1:0] a_s = '0;
	dmem_req_t             dreq_s = '0;

	int prog_len = 0;
	int total_events = 0;
	int seen = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int limit = 0;

	tb_clock i_clock (
		.clk (clk),
		.rst (rst)
	);

	avr_core i_dut (
		.clk      (clk),
		.rst      (rst),
		.pmem_ce  (pmem_ce),
		.pmem_a   (pmem_a),
		.pmem_d   (pmem_d),
		.dmem_req (dmem_req),
		.dmem_di  (dmem_di),
		.io_wr    (io_wr),
		.dbg_pc   (dbg_pc)
	);

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic match_event(input wr_event_t got);
		wr_event_t exp;
		if (expected.size() == 0) begin
			errors++;
			$display("unexpected extra %s write at %0d ns, address %h, data %h",
				got.is_io ? "I/O" : "data", $time, got.addr, got.data);
		end else begin
			exp = expected.pop_front();
			seen++;
			check_value("write kind (1 is I/O)", got.is_io, exp.is_io);
			check_value(got.is_io ? "io_wr.addr" : "dmem_req.addr", got.addr, exp.addr);
			check_value(got.is_io ? "io_wr.data" : "dmem_req.wdata", got.data, exp.data);
		end
	endtask

	// Lines hold a kind letter and two hex numbers; # starts a comment.
	task automatic load_cases();
		int          fd;
		int          ch;
		int          n;
		logic [15:0] addr;
		logic [15:0] value;
		fd = $fopen("tests/program_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open the cases file tests/program_cases.txt");
			return;
		end
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == "#") begin
				while (ch != -1 && ch != "\n")
					ch = $fgetc(fd);
			end else if (ch == "p" || ch == "d" || ch == "w" || ch == "o") begin
				n = $fscanf(fd, "%h %h", addr, value);
				if (n != 2) begin
					errors++;
					$display("malformed line of kind %c in the cases file", ch);
				end else if (ch == "p") begin
					prog[addr[10:0]] = value;
					if (int'(addr) + 1 > prog_len)
						prog_len = int'(addr) + 1;
				end else if (ch == "d") begin
					dmem[addr[12:0]] = value[7:0];
				end else begin
					expected.push_back({ch == "o", addr[12:0], value[7:0]});
				end
			end else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
				errors++;
				$display("unknown line kind %c in the cases file", ch);
			end
			if (ch != -1)
				ch = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// Memories answer at the edge, their outputs change just after it.
	always @(posedge clk) begin
		#drive_delay;
		if (ce_s)
			pmem_d = prog[a_s];
		dmem_di = dmem[dreq_s.addr];
		if (dreq_s.we)
			dmem[dreq_s.addr] = dreq_s.wdata;
	end

	always @(negedge clk) begin
		ce_s = pmem_ce;
		a_s = pmem_a;
		dreq_s = dmem_req;
		if (rst) begin
			check_value("pmem_a", pmem_a, 16'd0);
			check_value("pmem_ce", pmem_ce, 16'd1);
			check_value("dmem_req.we", dmem_req.we, 16'd0);
			check_value("io_wr.we", io_wr.we, 16'd0);
		end else begin
			if (dmem_req.we)
				match_event({1'b0, dmem_req.addr, dmem_req.wdata});
			if (io_wr.we)
				match_event({1'b1, 7'd0, io_wr.addr, io_wr.data});
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles >= limit) begin
			errors++;
			$display("timeout: the program did not reach its final jump in %0d cycles", limit);
			$display("checks: %0d, errors: %0d, writes matched: %0d of %0d",
				checks, errors, seen, total_events);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		pmem_d = 16'h0000;
		dmem_di = 8'h00;
		for (int i = 0; i < 2048; i++)
			prog[i] = 16'h0000;
		for (int i = 0; i < 8192; i++)
			dmem[i] = 8'(i) ^ 8'(i >> 5);
		load_cases();
		total_events = expected.size();
		limit = 2 * prog_len + 2 * total_events + 50;
		if (errors == 0) begin
			// the program ends in a jump to itself.
			while (rst || dbg_pc !== pmem_width'(prog_len - 1))
				@(negedge clk);
			repeat (3) @(negedge clk);
			if (expected.size() != 0) begin
				errors++;
				$display("%0d expected writes never happened", expected.size());
			end
		end
		$display("checks: %0d, errors: %0d, writes matched: %0d of %0d",
			checks, errors, seen, total_events);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tests/program_cases.txt ====
# kind addr value, in hex. p = program word, d = preloaded data byte,
# w = expected data write (address, byte), o = expected OUT (port, byte).
p 000 ef00  # ldi r16, 0xf0
p 001 e112  # ldi r17, 0x12
p 002 e220  # ldi r18, 0x20
p 003 e334  # ldi r19, 0x34
p 004 0f02  # add r16, r18
p 005 1f13  # adc r17, r19
p 006 b901  # out 0x01, r16
o 01 10
p 007 b912  # out 0x02, r17
o 02 47
p 008 1b02  # sub r16, r18
p 009 0b13  # sbc r17, r19
p 00a b903  # out 0x03, r16
o 03 f0
p 00b b914  # out 0x04, r17
o 04 12
p 00c e54a  # ldi r20, 0x5a
p 00d 704f  # andi r20, 0x0f
p 00e 6340  # ori r20, 0x30
p 00f ef5f  # ldi r21, 0xff
p 010 2745  # eor r20, r21
p 011 2f64  # mov r22, r20
p 012 b965  # out 0x05, r22
o 05 c5
p 013 9560  # com r22
p 014 b966  # out 0x06, r22
o 06 3a
p 015 9561  # neg r22
p 016 b967  # out 0x07, r22
o 07 c6
p 017 9563  # inc r22
p 018 955a  # dec r21
p 019 b968  # out 0x08, r22
o 08 c7
p 01a b959  # out 0x09, r21
o 09 fe
p 01b 9566  # lsr r22
p 01c 9557  # ror r21
p 01d 9545  # asr r20
p 01e 9562  # swap r22
p 01f b96a  # out 0x0a, r22
o 0a 36
p 020 b95b  # out 0x0b, r21
o 0b ff
p 021 b94c  # out 0x0c, r20
o 0c e2
p 022 3e42  # cpi r20, 0xe2
p 023 f009  # brbs z, +1 (taken)
p 024 bf4f  # out 0x3f, r20 (skipped)
p 025 f409  # brbc z, +1
p 026 b94d  # out 0x0d, r20
o 0d e2
p 027 3f40  # cpi r20, 0xf0
p 028 f408  # brbc c, +1
p 029 b94e  # out 0x0e, r20
o 0e e2
p 02a f00a  # brbs n, +1 (taken)
p 02b bf4f  # out 0x3f, r20 (skipped)
p 02c e870  # ldi r23, 0x80
p 02d 3071  # cpi r23, 0x01
p 02e f40b  # brbc v, +1
p 02f b97f  # out 0x0f, r23
o 0f 80
p 030 f00b  # brbs v, +1 (taken)
p 031 bf7f  # out 0x3f, r23 (skipped)
p 032 1702  # cp r16, r18
p 033 0711  # cpc r17, r17 (z stays clear)
p 034 f009  # brbs z, +1
p 035 bb10  # out 0x10, r17
o 10 12
p 036 1711  # cp r17, r17
p 037 0700  # cpc r16, r16 (z stays set)
p 038 f409  # brbc z, +1
p 039 bb01  # out 0x11, r16
o 11 f0
p 03a c001  # rjmp +1
p 03b bf0f  # out 0x3f, r16 (skipped)
p 03c e0a0  # ldi r26, 0x00
p 03d e0b1  # ldi r27, 0x01
p 03e 930d  # st x+, r16
w 0100 f0
p 03f 931d  # st x+, r17
w 0101 12
p 040 e0c4  # ldi r28, 0x04
p 041 e0d1  # ldi r29, 0x01
p 042 934a  # st -y, r20
w 0103 e2
p 043 937a  # st -y, r23
w 0102 80
p 044 902e  # ld r2, -x
p 045 ba22  # out 0x12, r2
o 12 12
p 046 8038  # ld r3, y
p 047 ba33  # out 0x13, r3
o 13 80
p 048 e0e0  # ldi r30, 0x00
p 049 e0f2  # ldi r31, 0x02
p 04a 9041  # ld r4, z+
p 04b 8050  # ld r5, z
p 04c ba44  # out 0x14, r4
o 14 a5
p 04d ba55  # out 0x15, r5
o 15 3c
p 04e 8240  # st z, r4
w 0201 a5
p 04f 925d  # st x+, r5
w 0101 3c
p 050 906c  # ld r6, x
p 051 ba66  # out 0x16, r6
o 16 80
p 052 cfff  # rjmp -1 (end of program)
d 0200 a5
d 0201 3c

// ==== sources.f ====
logic/avr_isa_pkg.sv
logic/avr_core_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/register_file.sv
logic/sequencer.sv
logic/avr_core.sv
tests/tb_clock.sv
tests/avr_core_tb.sv
